// File: verilog/icache_pkg.sv
// icache package with the address split, widths, bank geometry and controller states
`default_nettype none

package icache_pkg;

    // address split
    localparam int addr_w   = 32;
    localparam int tag_w    = 21;
    localparam int index_w  = 7;
    localparam int offset_w = 4;

    // line and word widths
    localparam int line_w = 128;
    localparam int word_w = 64;

    // data array geometry with two banks per way
    localparam int bank_depth  = 64;
    localparam int bank_addr_w = 6;

    // refill burst
    localparam int beats_per_line = 2;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic             valid;
    } tagv_t;

    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_read   = 3'd1,
        st_miss   = 3'd2,
        st_data   = 3'd3,
        st_refill = 3'd4
    } state_t;

endpackage

`default_nettype wire

// File: verilog/entry_array.sv
// resettable entry array with one write port and a combinational read
`timescale 1ns/1ns
`default_nettype none

module entry_array #(
    parameter type entry_t = logic,
    parameter int  depth   = 128
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           i_wen,
    input  wire [icache_pkg::index_w-1:0] i_waddr,
    input  entry_t                        i_wdata,
    input  wire [icache_pkg::index_w-1:0] i_raddr,
    output entry_t                        o_rdata
);

    entry_t entries [depth];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                entries[i] <= entry_t'(0);
            end
        end else if (i_wen) begin
            entries[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata = entries[i_raddr];

endmodule

`default_nettype wire

// File: verilog/sram_bank.sv
// single-port sram bank for cache lines with chip enable, write enable and registered read
`timescale 1ns/1ns
`default_nettype none

module sram_bank (
    input  wire                               clk,
    input  wire                               i_cen,
    input  wire                               i_wen,
    input  wire [icache_pkg::bank_addr_w-1:0] i_addr,
    input  wire [icache_pkg::line_w-1:0]      i_wdata,
    output logic [icache_pkg::line_w-1:0]     o_rdata
);

    logic [icache_pkg::line_w-1:0] mem [icache_pkg::bank_depth];

    always_ff @(posedge clk) begin
        if (i_cen) begin
            if (i_wen) begin
                mem[i_addr] <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr];
            end
        end
    end

    // read data holds until the next read

endmodule

`default_nettype wire

// File: verilog/icache_ctrl.sv
// icache controller for tag compare, replacement, miss FSM, refill and data array control
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl (
    input  wire                                      clk,
    input  wire                                      rst,
    // fetch side
    input  wire                                      i_req,
    input  wire [icache_pkg::addr_w-1:0]             i_addr,
    output logic                                     o_ready,
    output logic                                     o_valid,
    output logic [icache_pkg::word_w-1:0]            o_rdata,
    // burst read port
    output logic                                     o_rd_req,
    output logic [icache_pkg::addr_w-1:0]            o_rd_addr,
    input  wire                                      i_rd_ready,
    input  wire [icache_pkg::word_w-1:0]             i_rdata,
    input  wire                                      i_rvalid,
    input  wire                                      i_rlast,
    // tag/valid arrays
    output logic [1:0]                               o_tagv_wen,
    output logic [icache_pkg::index_w-1:0]           o_tagv_windex,
    output icache_pkg::tagv_t                        o_tagv_wdata,
    input  icache_pkg::tagv_t                        i_tagv0,
    input  icache_pkg::tagv_t                        i_tagv1,
    // recently-used array
    output logic                                     o_ru_wen,
    output logic                                     o_ru_way,
    input  wire                                      i_ru_way,
    // data banks
    output logic [3:0]                               o_bank_cen,
    output logic [3:0]                               o_bank_wen,
    output logic [3:0][icache_pkg::bank_addr_w-1:0]  o_bank_addr,
    output logic [icache_pkg::line_w-1:0]            o_bank_wdata,
    input  wire  [3:0][icache_pkg::line_w-1:0]       i_bank_rdata,
    // statistics
    output logic                                     o_hit_pulse,
    output logic                                     o_req_pulse
);

    icache_pkg::state_t state;
    icache_pkg::state_t state_nxt;

    logic [icache_pkg::tag_w-1:0]   tag_i;
    logic [icache_pkg::index_w-1:0] index_i;
    logic                           hit_way0;
    logic                           hit_way1;
    logic                           hit;
    logic                           refill_way;
    logic                           accept;

    // request buffer
    logic [icache_pkg::addr_w-1:0]  addr_r;
    logic                           hit_way1_r;
    logic                           refill_way_r;
    logic [icache_pkg::index_w-1:0] index_r;
    logic                           word_sel;

    logic [$clog2(icache_pkg::beats_per_line)-1:0]                 beat_cnt;
    logic [icache_pkg::beats_per_line-1:0][icache_pkg::word_w-1:0] line_buf;
    logic [icache_pkg::beats_per_line-1:0][icache_pkg::word_w-1:0] hit_line;

    logic [3:0]                     bank_rd;
    logic [3:0]                     bank_wr;

    assign tag_i   = i_addr[icache_pkg::addr_w-1 -: icache_pkg::tag_w];
    assign index_i = i_addr[icache_pkg::offset_w +: icache_pkg::index_w];

    assign hit_way0 = i_tagv0.valid && (i_tagv0.tag == tag_i);
    assign hit_way1 = i_tagv1.valid && (i_tagv1.tag == tag_i);
    assign hit      = hit_way0 || hit_way1;

    // fill an invalid way first (way 0 before way 1) or else the least recently used
    assign refill_way = (i_tagv0.valid && i_tagv1.valid) ? ~i_ru_way : i_tagv0.valid;

    assign o_ready = (state == icache_pkg::st_idle) || (state == icache_pkg::st_read);
    assign accept  = i_req && o_ready;

    assign o_req_pulse = accept;
    assign o_hit_pulse = accept && hit;

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_r       <= i_addr;
            hit_way1_r   <= hit_way1;
            refill_way_r <= refill_way;
        end
    end

    assign index_r  = addr_r[icache_pkg::offset_w +: icache_pkg::index_w];
    assign word_sel = addr_r[icache_pkg::offset_w-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            icache_pkg::st_idle, icache_pkg::st_read: begin
                if (accept) begin
                    state_nxt = hit ? icache_pkg::st_read : icache_pkg::st_miss;
                end else begin
                    state_nxt = icache_pkg::st_idle;
                end
            end
            icache_pkg::st_miss: begin
                if (i_rd_ready) begin
                    state_nxt = icache_pkg::st_data;
                end
            end
            icache_pkg::st_data: begin
                if (i_rvalid && i_rlast) begin
                    state_nxt = icache_pkg::st_refill;
                end
            end
            icache_pkg::st_refill: state_nxt = icache_pkg::st_idle;
            default:               state_nxt = icache_pkg::st_idle;
        endcase
    end

    // line fetch
    assign o_rd_req  = (state == icache_pkg::st_miss);
    assign o_rd_addr = {addr_r[icache_pkg::addr_w-1:icache_pkg::offset_w],
                        {icache_pkg::offset_w{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst || (o_rd_req && i_rd_ready)) begin
            beat_cnt <= '0;
        end else if ((state == icache_pkg::st_data) && i_rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // beat 0 lands in the low half
    always_ff @(posedge clk) begin
        if ((state == icache_pkg::st_data) && i_rvalid) begin
            line_buf[beat_cnt] <= i_rdata;
        end
    end

    // response word
    assign hit_line = hit_way1_r ? i_bank_rdata[{1'b1, index_r[icache_pkg::index_w-1]}]
                                 : i_bank_rdata[{1'b0, index_r[icache_pkg::index_w-1]}];

    always_comb begin
        o_valid = 1'b0;
        o_rdata = hit_line[word_sel];
        if (state == icache_pkg::st_read) begin
            o_valid = 1'b1;
        end else if (state == icache_pkg::st_refill) begin
            o_valid = 1'b1;
            o_rdata = line_buf[word_sel];
        end
    end

    // tag/valid update on refill
    assign o_tagv_windex = index_r;
    assign o_tagv_wdata  = '{tag:   addr_r[icache_pkg::addr_w-1 -: icache_pkg::tag_w],
                             valid: 1'b1};
    assign o_tagv_wen[0] = (state == icache_pkg::st_refill) && !refill_way_r;
    assign o_tagv_wen[1] = (state == icache_pkg::st_refill) && refill_way_r;

    // way used by this request
    assign o_ru_wen = accept;
    assign o_ru_way = hit ? hit_way1 : refill_way;

    // bank number is {way, index msb}
    assign bank_rd = {4{accept}}
                   & {index_i[icache_pkg::index_w-1], ~index_i[icache_pkg::index_w-1],
                      index_i[icache_pkg::index_w-1], ~index_i[icache_pkg::index_w-1]};
    assign bank_wr = {4{state == icache_pkg::st_refill}}
                   & (4'b0001 << {refill_way_r, index_r[icache_pkg::index_w-1]});

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            o_bank_cen[b]  = bank_rd[b] || bank_wr[b];
            o_bank_wen[b]  = bank_wr[b];
            o_bank_addr[b] = bank_wr[b] ? index_r[icache_pkg::bank_addr_w-1:0]
                                        : index_i[icache_pkg::bank_addr_w-1:0];
        end
    end

    assign o_bank_wdata = line_buf;

endmodule

`default_nettype wire

// File: verilog/icache_top.sv
// icache top level joining the controller, the entry arrays and four data banks
`timescale 1ns/1ns
`default_nettype none

module icache_top (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           i_req,
    input  wire [icache_pkg::addr_w-1:0]  i_addr,
    output logic                          o_ready,
    output logic                          o_valid,
    output logic [icache_pkg::word_w-1:0] o_rdata,
    output logic                          o_rd_req,
    output logic [icache_pkg::addr_w-1:0] o_rd_addr,
    input  wire                           i_rd_ready,
    input  wire [icache_pkg::word_w-1:0]  i_rdata,
    input  wire                           i_rvalid,
    input  wire                           i_rlast,
    output logic                          o_hit_pulse,
    output logic                          o_req_pulse
);

    logic [1:0]                                tagv_wen;
    logic [icache_pkg::index_w-1:0]            tagv_windex;
    icache_pkg::tagv_t                         tagv_wdata;
    icache_pkg::tagv_t                         tagv0;
    icache_pkg::tagv_t                         tagv1;
    logic                                      ru_wen;
    logic                                      ru_wway;
    logic                                      ru_way;
    logic [3:0]                                bank_cen;
    logic [3:0]                                bank_wen;
    logic [3:0][icache_pkg::bank_addr_w-1:0]   bank_addr;
    logic [icache_pkg::line_w-1:0]             bank_wdata;
    logic [3:0][icache_pkg::line_w-1:0]        bank_rdata;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .i_req         (i_req),
        .i_addr        (i_addr),
        .o_ready       (o_ready),
        .o_valid       (o_valid),
        .o_rdata       (o_rdata),
        .o_rd_req      (o_rd_req),
        .o_rd_addr     (o_rd_addr),
        .i_rd_ready    (i_rd_ready),
        .i_rdata       (i_rdata),
        .i_rvalid      (i_rvalid),
        .i_rlast       (i_rlast),
        .o_tagv_wen    (tagv_wen),
        .o_tagv_windex (tagv_windex),
        .o_tagv_wdata  (tagv_wdata),
        .i_tagv0       (tagv0),
        .i_tagv1       (tagv1),
        .o_ru_wen      (ru_wen),
        .o_ru_way      (ru_wway),
        .i_ru_way      (ru_way),
        .o_bank_cen    (bank_cen),
        .o_bank_wen    (bank_wen),
        .o_bank_addr   (bank_addr),
        .o_bank_wdata  (bank_wdata),
        .i_bank_rdata  (bank_rdata),
        .o_hit_pulse   (o_hit_pulse),
        .o_req_pulse   (o_req_pulse)
    );

    // lookups read at the incoming index
    entry_array #(.entry_t(icache_pkg::tagv_t), .depth(2 ** icache_pkg::index_w)) u_tagv0 (
        .clk     (clk),
        .rst     (rst),
        .i_wen   (tagv_wen[0]),
        .i_waddr (tagv_windex),
        .i_wdata (tagv_wdata),
        .i_raddr (i_addr[icache_pkg::offset_w +: icache_pkg::index_w]),
        .o_rdata (tagv0)
    );

    entry_array #(.entry_t(icache_pkg::tagv_t), .depth(2 ** icache_pkg::index_w)) u_tagv1 (
        .clk     (clk),
        .rst     (rst),
        .i_wen   (tagv_wen[1]),
        .i_waddr (tagv_windex),
        .i_wdata (tagv_wdata),
        .i_raddr (i_addr[icache_pkg::offset_w +: icache_pkg::index_w]),
        .o_rdata (tagv1)
    );

    entry_array #(.entry_t(logic), .depth(2 ** icache_pkg::index_w)) u_ru (
        .clk     (clk),
        .rst     (rst),
        .i_wen   (ru_wen),
        .i_waddr (i_addr[icache_pkg::offset_w +: icache_pkg::index_w]),
        .i_wdata (ru_wway),
        .i_raddr (i_addr[icache_pkg::offset_w +: icache_pkg::index_w]),
        .o_rdata (ru_way)
    );

    // banks 0/1 hold way 0 and banks 2/3 hold way 1 with the index msb picking the bank
    sram_bank u_bank0 (
        .clk     (clk),
        .i_cen   (bank_cen[0]),
        .i_wen   (bank_wen[0]),
        .i_addr  (bank_addr[0]),
        .i_wdata (bank_wdata),
        .o_rdata (bank_rdata[0])
    );

    sram_bank u_bank1 (
        .clk     (clk),
        .i_cen   (bank_cen[1]),
        .i_wen   (bank_wen[1]),
        .i_addr  (bank_addr[1]),
        .i_wdata (bank_wdata),
        .o_rdata (bank_rdata[1])
    );

    sram_bank u_bank2 (
        .clk     (clk),
        .i_cen   (bank_cen[2]),
        .i_wen   (bank_wen[2]),
        .i_addr  (bank_addr[2]),
        .i_wdata (bank_wdata),
        .o_rdata (bank_rdata[2])
    );

    sram_bank u_bank3 (
        .clk     (clk),
        .i_cen   (bank_cen[3]),
        .i_wen   (bank_wen[3]),
        .i_addr  (bank_addr[3]),
        .i_wdata (bank_wdata),
        .o_rdata (bank_rdata[3])
    );

endmodule

`default_nettype wire

// File: dv/icache_tb.sv
// icache testbench with golden-file requests, a burst memory model and a response checker
`timescale 1ns/1ns
`default_nettype none

module icache_tb;

    localparam int half_period   = 50;
    localparam int reset_cycles  = 8;
    localparam int drive_delay   = 1;
    localparam int ready_timeout = 40;
    localparam int drain_timeout = 40;
    localparam int max_lines     = 64;

    logic                          clk;
    logic                          rst;
    logic                          i_req;
    logic [icache_pkg::addr_w-1:0] i_addr;
    logic                          o_ready;
    logic                          o_valid;
    logic [icache_pkg::word_w-1:0] o_rdata;
    logic                          o_rd_req;
    logic [icache_pkg::addr_w-1:0] o_rd_addr;
    logic                          i_rd_ready;
    logic [icache_pkg::word_w-1:0] i_rdata;
    logic                          i_rvalid;
    logic                          i_rlast;
    logic                          o_hit_pulse;
    logic                          o_req_pulse;

    integer seed = 32'hacbe_9b63;

    // golden table
    logic [31:0] gold_addr [max_lines];
    logic [63:0] gold_word [max_lines];
    bit          gold_hit  [max_lines];
    int          n_gold = 0;
    int          n_hits = 0;

    // outstanding responses in acceptance order
    logic [31:0] exp_addr_q [$];
    logic [63:0] exp_word_q [$];
    bit          exp_hit_q  [$];
    int          exp_cyc_q  [$];

    int          cycle_cnt   = 0;
    int          errors      = 0;
    int          req_pulses  = 0;
    int          hit_pulses  = 0;
    int          fill_cnt    = 0;
    int          misses_done = 0;
    logic [31:0] fill_addr   = '0;
    bit          aborted     = 1'b0;

    icache_top u_icache_top (
        .clk         (clk),
        .rst         (rst),
        .i_req       (i_req),
        .i_addr      (i_addr),
        .o_ready     (o_ready),
        .o_valid     (o_valid),
        .o_rdata     (o_rdata),
        .o_rd_req    (o_rd_req),
        .o_rd_addr   (o_rd_addr),
        .i_rd_ready  (i_rd_ready),
        .i_rdata     (i_rdata),
        .i_rvalid    (i_rvalid),
        .i_rlast     (i_rlast),
        .o_hit_pulse (o_hit_pulse),
        .o_req_pulse (o_req_pulse)
    );

    initial clk = 1'b0;
    always #half_period clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // memory word at 8-byte address a
    function automatic logic [63:0] beat_word(input logic [31:0] a);
        beat_word = {~a, a};
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout while waiting: %s", what);
    endtask

    task automatic load_golden();
        int          fd;
        int          got;
        string       text;
        logic [31:0] a;
        logic [63:0] w;
        int          h;
        fd = $fopen("dv/icache_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file dv/icache_golden.txt");
            errors++;
            aborted = 1'b1;
        end else begin
            while ($fgets(text, fd) != 0) begin
                if (text.len() > 3 && text.getc(0) != "#") begin
                    got = $sscanf(text, "%h %h %d", a, w, h);
                    if (got != 3 || n_gold >= max_lines) begin
                        $display("Golden line could not be used: %s", text);
                        errors++;
                    end else begin
                        gold_addr[n_gold] = a;
                        gold_word[n_gold] = w;
                        gold_hit[n_gold]  = (h != 0);
                        if (h != 0) begin
                            n_hits++;
                        end
                        n_gold++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one refill with the address handshake after 0..3 cycles and two beats with random gaps
    task automatic serve_line(input logic [31:0] line_addr);
        int delay;
        int gap;
        fill_cnt++;
        fill_addr = line_addr;
        delay = $unsigned($random(seed)) % 4;
        @(posedge clk);
        #drive_delay;
        repeat (delay) begin
            @(posedge clk);
            #drive_delay;
        end
        i_rd_ready = 1'b1;
        @(posedge clk);
        #drive_delay;
        i_rd_ready = 1'b0;
        for (int b = 0; b < 2; b++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                #drive_delay;
            end
            i_rvalid = 1'b1;
            i_rlast  = (b == 1);
            i_rdata  = beat_word(line_addr + 32'(8 * b));
            @(posedge clk);
            #drive_delay;
            i_rvalid = 1'b0;
            i_rlast  = 1'b0;
        end
    endtask

    initial begin
        i_rd_ready = 1'b0;
        i_rvalid   = 1'b0;
        i_rlast    = 1'b0;
        i_rdata    = '0;
        forever begin
            @(negedge clk);
            if (!rst && o_rd_req) begin
                serve_line(o_rd_addr);
            end
        end
    end

    task automatic check_response();
        logic [31:0] addr;
        logic [63:0] word;
        bit          hit;
        int          acc_cyc;
        if (exp_word_q.size() == 0) begin
            report_mismatch("response without an outstanding request");
        end else begin
            addr    = exp_addr_q.pop_front();
            word    = exp_word_q.pop_front();
            hit     = exp_hit_q.pop_front();
            acc_cyc = exp_cyc_q.pop_front();
            if (o_rdata !== word) begin
                report_mismatch($sformatf("addr %h read %h, expected %h", addr, o_rdata, word));
            end
            if (hit) begin
                if (cycle_cnt != acc_cyc + 1) begin
                    report_mismatch($sformatf("hit at %h answered %0d cycles after acceptance",
                                              addr, cycle_cnt - acc_cyc));
                end
                if (o_rd_req !== 1'b0) begin
                    report_mismatch($sformatf("read port active on hit at %h", addr));
                end
            end else begin
                misses_done++;
                if (fill_cnt != misses_done) begin
                    report_mismatch($sformatf("miss at %h without a line fetch", addr));
                end else if (fill_addr !== {addr[31:4], 4'b0000}) begin
                    report_mismatch($sformatf("miss at %h fetched line %h", addr, fill_addr));
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (o_req_pulse) begin
                req_pulses++;
            end
            if (o_hit_pulse) begin
                hit_pulses++;
            end
            if (o_valid) begin
                check_response();
            end
        end
    end

    task automatic check_reset_state();
        if (o_ready !== 1'b1 || o_valid !== 1'b0 || o_rd_req !== 1'b0) begin
            report_mismatch("handshake outputs wrong after reset");
        end
        if (o_hit_pulse !== 1'b0 || o_req_pulse !== 1'b0) begin
            report_mismatch("statistics pulses active after reset");
        end
    endtask

    task automatic run_requests();
        int  waited;
        int  acc_cyc;
        bit  prev_hit;
        prev_hit = 1'b0;
        for (int i = 0; i < n_gold && !aborted; i++) begin
            i_req  = 1'b1;
            i_addr = gold_addr[i];
            waited = 0;
            @(negedge clk);
            while (!o_ready && waited < ready_timeout) begin
                @(negedge clk);
                waited++;
            end
            if (!o_ready) begin
                report_timeout($sformatf("request %0d at %h was never accepted", i, gold_addr[i]));
                aborted = 1'b1;
            end else begin
                // hits behind hits must not stall
                if (prev_hit && gold_hit[i] && waited != 0) begin
                    report_mismatch($sformatf("hit stream stalled before %h", gold_addr[i]));
                end
                if (o_req_pulse !== 1'b1 || o_hit_pulse !== gold_hit[i]) begin
                    report_mismatch($sformatf("pulses for %h: req %b hit %b, expected hit %b",
                                              gold_addr[i], o_req_pulse, o_hit_pulse,
                                              gold_hit[i]));
                end
                acc_cyc  = cycle_cnt;
                prev_hit = gold_hit[i];
                @(posedge clk);
                #drive_delay;
                exp_addr_q.push_back(gold_addr[i]);
                exp_word_q.push_back(gold_word[i]);
                exp_hit_q.push_back(gold_hit[i]);
                exp_cyc_q.push_back(acc_cyc);
            end
        end
        i_req = 1'b0;
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while (exp_word_q.size() != 0 && waited < drain_timeout) begin
            @(posedge clk);
            #drive_delay;
            waited++;
        end
        if (exp_word_q.size() != 0) begin
            report_timeout($sformatf("%0d responses never arrived", exp_word_q.size()));
        end
        // idle tail to catch stray responses
        repeat (4) @(posedge clk);
        #drive_delay;
    endtask

    task automatic check_counters();
        if (req_pulses != n_gold) begin
            report_mismatch($sformatf("%0d request pulses, expected %0d", req_pulses, n_gold));
        end
        if (hit_pulses != n_hits) begin
            report_mismatch($sformatf("%0d hit pulses, expected %0d", hit_pulses, n_hits));
        end
    endtask

    initial begin
        rst    = 1'b1;
        i_req  = 1'b0;
        i_addr = '0;
        load_golden();
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        @(posedge clk);
        #drive_delay;
        if (!aborted) begin
            run_requests();
        end
        if (!aborted) begin
            drain_responses();
            check_counters();
        end
        $display("icache_tb: %0d requests, %0d req pulses, %0d hit pulses, %0d errors",
                 n_gold, req_pulses, hit_pulses, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: icache_sub.f
verilog/icache_pkg.sv
verilog/entry_array.sv
verilog/sram_bank.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
dv/icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= icache_sub.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test OK

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

$(LOG): $(SIM)
	-$(SIM) > $(LOG) 2>&1

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

check: $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || { echo "FAIL, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/icache_golden.txt
# columns: request address (hex), expected 64-bit word (hex), expected hit (1) or miss (0)
# word for address X is {~A, A} with A = X with the low 3 bits cleared
00000100 FFFFFEFF00000100 0
00000108 FFFFFEF700000108 1
00000100 FFFFFEFF00000100 1
00000108 FFFFFEF700000108 1
00000500 FFFFFAFF00000500 0
00000508 FFFFFAF700000508 1
00000100 FFFFFEFF00000100 1
00000500 FFFFFAFF00000500 1
00000108 FFFFFEF700000108 1
00000508 FFFFFAF700000508 1
# index 0x05, three tags competing for two ways
00001058 FFFFEFA700001058 0
00001050 FFFFEFAF00001050 1
00002050 FFFFDFAF00002050 0
00002058 FFFFDFA700002058 1
00001050 FFFFEFAF00001050 1
00002050 FFFFDFAF00002050 1
00001058 FFFFEFA700001058 1
00003050 FFFFCFAF00003050 0
00001050 FFFFEFAF00001050 1
00003058 FFFFCFA700003058 1
00002050 FFFFDFAF00002050 0
00003050 FFFFCFAF00003050 1
00001058 FFFFEFA700001058 0
# index 0x45, upper bank half
00010450 FFFEFBAF00010450 0
00020458 FFFDFBA700020458 0
00010458 FFFEFBA700010458 1
00020450 FFFDFBAF00020450 1
00030450 FFFCFBAF00030450 0
00020458 FFFDFBA700020458 1
00030458 FFFCFBA700030458 1
00010450 FFFEFBAF00010450 0
00030450 FFFCFBAF00030450 1
# final hit stream across indices
00000100 FFFFFEFF00000100 1
00000508 FFFFFAF700000508 1
00001050 FFFFEFAF00001050 1
00003058 FFFFCFA700003058 1
00010458 FFFEFBA700010458 1
